//--- source/miim_pkg.sv
// Shared definitions for the MII management block.
// Register map, frame constants and the frame engine states.
// Referenced by scoped names from the RTL and the testbench.

package miim_pkg;

   // ==============================
   // APB side
   // ==============================
   typedef logic [31:0] apb_word_t;
   typedef logic [1:0]  reg_index_t;

   // Word offsets 0..3, upper half of the map is unmapped
   localparam reg_index_t REG_MCR = 2'd0;
   localparam reg_index_t REG_MDR = 2'd1;
   localparam reg_index_t REG_DIV = 2'd2;
   localparam reg_index_t REG_IRQ = 2'd3;

   // ==============================
   // MDIO side
   // ==============================
   typedef logic [15:0] mdio_data_t;
   typedef logic [4:0]  phy_addr_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [1:0]  mdio_op_t;
   typedef logic [7:0]  clk_div_t;

   // Clause-22 opcodes
   localparam mdio_op_t OP_WRITE = 2'b01;
   localparam mdio_op_t OP_READ  = 2'b10;

   localparam int PREAMBLE_BITS = 32;
   // Start, opcode, addresses, turnaround and data
   localparam int FRAME_BITS    = 32;

   typedef enum logic [1:0] {ST_IDLE, ST_PREAMBLE, ST_FRAME, ST_DONE} engine_state_t;

endpackage

//--- source/miim_apb_slave.sv
// APB access decoder for the management registers.
// Turns the access phase into one write strobe plus a register index,
// flags the unmapped half of the map and stalls MCR writes while busy.

`timescale 1ns/1ps

module miim_apb_slave (
   input  logic                 pclk,
   input  logic                 presetn_sync,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [4:0]           paddr,
   input  logic                 busy,
   output logic                 pready,
   output logic                 pslverr,
   output logic                 wr_strobe,
   output miim_pkg::reg_index_t rd_index,
   output logic                 unmapped
);

   logic access;
   logic mcr_wr;
   logic hold_q;

   // Access phase of a selected transfer
   assign access   = psel & penable;

   // Offsets 4..7 have no register behind them
   assign unmapped = paddr[4];
   assign rd_index = miim_pkg::reg_index_t'(paddr[3:2]);

   // Command write, the only access that may wait
   assign mcr_wr   = access & pwrite & ~unmapped & (rd_index == miim_pkg::REG_MCR);

   // Stall while the engine runs and for one cycle after busy drops
   assign pready   = ~(mcr_wr & (busy | hold_q));

   // Error only on unmapped offsets, always with pready high
   assign pslverr  = access & unmapped;

   // One pulse in the completing cycle, decoded by index downstream
   assign wr_strobe = access & pwrite & pready & ~unmapped;

   // Remembers that a command write was held off last cycle
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
      begin
         hold_q <= 1'b0;
      end
      else
      begin
         hold_q <= mcr_wr & busy;
      end
   end

endmodule

//--- source/miim_regs.sv
// Management registers MCR, MDR, DIV and IRQ with the read mux.
// Pulses start after a command write with a valid opcode and
// latches frame results and the interrupt flag from the engine.

`timescale 1ns/1ps

module miim_regs #(
   parameter miim_pkg::clk_div_t DEFAULT_CLK_DIV = 8'd4
) (
   input  logic                 pclk,
   input  logic                 presetn_sync,
   input  logic                 wr_strobe,
   input  miim_pkg::reg_index_t rd_index,
   input  logic                 unmapped,
   input  miim_pkg::apb_word_t  pwdata,
   input  logic                 busy,
   input  logic                 done,
   input  logic                 rd_valid,
   input  miim_pkg::mdio_data_t rd_data,
   output miim_pkg::apb_word_t  prdata,
   output logic                 start,
   output miim_pkg::mdio_op_t   op,
   output miim_pkg::phy_addr_t  phy_addr,
   output miim_pkg::reg_addr_t  reg_addr,
   output logic                 no_preamble,
   output miim_pkg::mdio_data_t wr_data,
   output miim_pkg::clk_div_t   clk_div,
   output logic                 irq
);

   logic               irq_en;
   logic               irq_flag;
   miim_pkg::mdio_op_t new_op;

   assign new_op = miim_pkg::mdio_op_t'(pwdata[1:0]);

   // ==============================
   // Control registers
   // ==============================
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
      begin
         op          <= '0;
         phy_addr    <= '0;
         reg_addr    <= '0;
         no_preamble <= 1'b0;
         start       <= 1'b0;
         clk_div     <= DEFAULT_CLK_DIV;
         irq_en      <= 1'b0;
         irq_flag    <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         if (wr_strobe && rd_index == miim_pkg::REG_MCR)
         begin
            op          <= new_op;
            phy_addr    <= pwdata[6:2];
            reg_addr    <= pwdata[11:7];
            no_preamble <= pwdata[12];
            // Unknown opcodes are stored but start nothing
            start       <= (new_op == miim_pkg::OP_WRITE) || (new_op == miim_pkg::OP_READ);
         end
         // Half-period below 2 is taken as 2
         if (wr_strobe && rd_index == miim_pkg::REG_DIV)
            clk_div <= (pwdata[7:0] < 8'd2) ? 8'd2 : pwdata[7:0];
         if (wr_strobe && rd_index == miim_pkg::REG_IRQ)
         begin
            irq_en <= pwdata[0];
            // Write one to clear
            if (pwdata[1])
               irq_flag <= 1'b0;
         end
         // A finishing frame wins over a clear in the same cycle
         if (done)
            irq_flag <= 1'b1;
      end
   end

   // MDR holds write data or the last read result
   always_ff @(posedge pclk)
   begin
      if (wr_strobe && rd_index == miim_pkg::REG_MDR)
         wr_data <= pwdata[15:0];
      else if (rd_valid)
         wr_data <= rd_data;
   end

   assign irq = irq_flag & irq_en;

   // ==============================
   // Read mux
   // ==============================
   always_comb
   begin
      prdata = '0;
      if (!unmapped)
      begin
         case (rd_index)
            miim_pkg::REG_MCR: prdata = {busy, 18'h0, no_preamble, reg_addr, phy_addr, op};
            miim_pkg::REG_MDR: prdata = {16'h0, wr_data};
            miim_pkg::REG_DIV: prdata = {24'h0, clk_div};
            default:           prdata = {30'h0, irq_flag, irq_en};
         endcase
      end
   end

endmodule

//--- source/miim_mdc_gen.sv
// MDC clock generator driven from pclk.
// Runs only while the frame engine is busy; mdc is low when idle.
// mdc_rise and mdc_fall are high in the cycle before mdc changes.

`timescale 1ns/1ps

module miim_mdc_gen (
   input  logic               pclk,
   input  logic               presetn_sync,
   input  logic               run,
   input  miim_pkg::clk_div_t clk_div,
   output logic               mdc,
   output logic               mdc_rise,
   output logic               mdc_fall
);

   miim_pkg::clk_div_t cnt;
   logic               tick;

   // Half-period reached, mdc flips on the next edge
   assign tick     = run && (cnt == clk_div - 8'd1);
   assign mdc_rise = tick & ~mdc;
   assign mdc_fall = tick & mdc;

   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
      begin
         cnt <= '0;
         mdc <= 1'b0;
      end
      else if (!run)
      begin
         // Restart so every frame begins from mdc low
         cnt <= '0;
         mdc <= 1'b0;
      end
      else if (tick)
      begin
         cnt <= '0;
         mdc <= ~mdc;
      end
      else
      begin
         cnt <= cnt + 8'd1;
      end
   end

endmodule

//--- source/miim_frame_engine.sv
// Clause-22 management frame engine.
// Sends an optional 32-bit preamble then start, opcode, addresses,
// turnaround and data on mdo; a read releases the line at turnaround
// and shifts mdi into rd_data. Drives on mdc falls, samples on rises.

`timescale 1ns/1ps

module miim_frame_engine (
   input  logic                 pclk,
   input  logic                 presetn_sync,
   input  logic                 start,
   input  miim_pkg::mdio_op_t   op,
   input  miim_pkg::phy_addr_t  phy_addr,
   input  miim_pkg::reg_addr_t  reg_addr,
   input  logic                 no_preamble,
   input  miim_pkg::mdio_data_t wr_data,
   input  logic                 mdc_rise,
   input  logic                 mdc_fall,
   input  logic                 mdi,
   output logic                 busy,
   output logic                 done,
   output logic                 rd_valid,
   output miim_pkg::mdio_data_t rd_data,
   output logic                 mdo,
   output logic                 mdo_en
);

   // Bit positions inside the frame, counted from the start bits
   localparam logic [4:0] TA_BIT   = 5'd14;
   localparam logic [4:0] DATA_BIT = 5'd16;

   miim_pkg::engine_state_t          state;
   logic [miim_pkg::FRAME_BITS-1:0]  frame_q;
   logic [4:0]                       bit_cnt;
   logic                             is_read;

   // ==============================
   // Control FSM
   // ==============================
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
      begin
         state    <= miim_pkg::ST_IDLE;
         frame_q  <= '1;
         bit_cnt  <= '0;
         is_read  <= 1'b0;
         busy     <= 1'b0;
         done     <= 1'b0;
         rd_valid <= 1'b0;
         mdo      <= 1'b1;
         mdo_en   <= 1'b0;
      end
      else
      begin
         done     <= 1'b0;
         rd_valid <= 1'b0;
         case (state)
            miim_pkg::ST_IDLE:
            begin
               if (start)
               begin
                  is_read <= (op == miim_pkg::OP_READ);
                  // Read frames carry ones in TA and data, line released there
                  frame_q <= (op == miim_pkg::OP_READ) ?
                             {2'b01, op, phy_addr, reg_addr, 2'b11, 16'hffff} :
                             {2'b01, op, phy_addr, reg_addr, 2'b10, wr_data};
                  bit_cnt <= '0;
                  busy    <= 1'b1;
                  mdo_en  <= 1'b1;
                  // First start bit is a zero
                  mdo     <= ~no_preamble;
                  state   <= no_preamble ? miim_pkg::ST_FRAME : miim_pkg::ST_PREAMBLE;
               end
            end
            miim_pkg::ST_PREAMBLE:
            begin
               if (mdc_fall)
               begin
                  if (bit_cnt == 5'(miim_pkg::PREAMBLE_BITS - 1))
                  begin
                     bit_cnt <= '0;
                     mdo     <= frame_q[miim_pkg::FRAME_BITS-1];
                     state   <= miim_pkg::ST_FRAME;
                  end
                  else
                     bit_cnt <= bit_cnt + 5'd1;
               end
            end
            miim_pkg::ST_FRAME:
            begin
               // Last bit sampled, hold it through the high half
               if (mdc_rise && bit_cnt == 5'(miim_pkg::FRAME_BITS - 1))
                  state <= miim_pkg::ST_DONE;
               if (mdc_fall)
               begin
                  bit_cnt <= bit_cnt + 5'd1;
                  frame_q <= {frame_q[miim_pkg::FRAME_BITS-2:0], 1'b1};
                  mdo     <= frame_q[miim_pkg::FRAME_BITS-2];
                  if (is_read && bit_cnt == TA_BIT - 5'd1)
                     mdo_en <= 1'b0;
               end
            end
            default:
            begin
               // Finish together with the final mdc fall
               if (mdc_fall)
               begin
                  busy     <= 1'b0;
                  done     <= 1'b1;
                  rd_valid <= is_read;
                  mdo      <= 1'b1;
                  mdo_en   <= 1'b0;
                  state    <= miim_pkg::ST_IDLE;
               end
            end
         endcase
      end
   end

   // Read capture, MSB first during the data phase
   always_ff @(posedge pclk)
   begin
      if (state == miim_pkg::ST_FRAME && mdc_rise && is_read && bit_cnt >= DATA_BIT)
         rd_data <= {rd_data[14:0], mdi};
   end

endmodule

//--- source/eth_miim_top.sv
// Top level of the MII management block.
// APB slave in front, register block in the middle, MDC generator
// and frame engine toward the PHY pins. Wires and instances only.

`timescale 1ns/1ps

module eth_miim_top #(
   parameter miim_pkg::clk_div_t DEFAULT_CLK_DIV = 8'd4
) (
   input  logic                pclk,
   input  logic                presetn_sync,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [4:0]          paddr,
   input  miim_pkg::apb_word_t pwdata,
   output miim_pkg::apb_word_t prdata,
   output logic                pready,
   output logic                pslverr,
   output logic                irq,
   output logic                mdc,
   output logic                mdo,
   output logic                mdo_en,
   input  logic                mdi
);

   // ==============================
   // Internal nets
   // ==============================
   logic                 wr_strobe;
   miim_pkg::reg_index_t rd_index;
   logic                 unmapped;
   logic                 busy;
   logic                 done;
   logic                 rd_valid;
   miim_pkg::mdio_data_t rd_data;
   logic                 start;
   miim_pkg::mdio_op_t   op;
   miim_pkg::phy_addr_t  phy_addr;
   miim_pkg::reg_addr_t  reg_addr;
   logic                 no_preamble;
   miim_pkg::mdio_data_t wr_data;
   miim_pkg::clk_div_t   clk_div;
   logic                 mdc_rise;
   logic                 mdc_fall;

   miim_apb_slave u_apb_slave (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .psel         ( psel         ),
      .penable      ( penable      ),
      .pwrite       ( pwrite       ),
      .paddr        ( paddr        ),
      .busy         ( busy         ),
      .pready       ( pready       ),
      .pslverr      ( pslverr      ),
      .wr_strobe    ( wr_strobe    ),
      .rd_index     ( rd_index     ),
      .unmapped     ( unmapped     )
   );

   miim_regs #(
      .DEFAULT_CLK_DIV ( DEFAULT_CLK_DIV )
   ) u_regs (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .wr_strobe    ( wr_strobe    ),
      .rd_index     ( rd_index     ),
      .unmapped     ( unmapped     ),
      .pwdata       ( pwdata       ),
      .busy         ( busy         ),
      .done         ( done         ),
      .rd_valid     ( rd_valid     ),
      .rd_data      ( rd_data      ),
      .prdata       ( prdata       ),
      .start        ( start        ),
      .op           ( op           ),
      .phy_addr     ( phy_addr     ),
      .reg_addr     ( reg_addr     ),
      .no_preamble  ( no_preamble  ),
      .wr_data      ( wr_data      ),
      .clk_div      ( clk_div      ),
      .irq          ( irq          )
   );

   // MDC runs only while a frame is in flight
   miim_mdc_gen u_mdc_gen (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .run          ( busy         ),
      .clk_div      ( clk_div      ),
      .mdc          ( mdc          ),
      .mdc_rise     ( mdc_rise     ),
      .mdc_fall     ( mdc_fall     )
   );

   miim_frame_engine u_frame_engine (
      .pclk         ( pclk         ),
      .presetn_sync ( presetn_sync ),
      .start        ( start        ),
      .op           ( op           ),
      .phy_addr     ( phy_addr     ),
      .reg_addr     ( reg_addr     ),
      .no_preamble  ( no_preamble  ),
      .wr_data      ( wr_data      ),
      .mdc_rise     ( mdc_rise     ),
      .mdc_fall     ( mdc_fall     ),
      .mdi          ( mdi          ),
      .busy         ( busy         ),
      .done         ( done         ),
      .rd_valid     ( rd_valid     ),
      .rd_data      ( rd_data      ),
      .mdo          ( mdo          ),
      .mdo_en       ( mdo_en       )
   );

endmodule

//--- test/eth_miim_checker.sv
// Concurrent protocol checks for the MII management top level.
// Bound onto eth_miim_top from this file.

`timescale 1ns/1ps

module eth_miim_checker (
   input logic       pclk,
   input logic       presetn_sync,
   input logic       psel,
   input logic       penable,
   input logic       pwrite,
   input logic [4:0] paddr,
   input logic       pready,
   input logic       pslverr,
   input logic       irq,
   input logic       mdc,
   input logic       mdo,
   input logic       mdo_en,
   input logic       busy
);

   logic cmd_seen;

   // Set once a command write has completed
   always_ff @(posedge pclk or negedge presetn_sync)
   begin
      if (!presetn_sync)
         cmd_seen <= 1'b0;
      else if (psel && penable && pwrite && pready && paddr[4:2] == 3'd0)
         cmd_seen <= 1'b1;
   end

   // Released line idles high
   a_mdo_idle: assert property (@(posedge pclk) disable iff (!presetn_sync)
      !mdo_en |-> mdo)
      else $error("mdo low while mdo_en is low");

   // MDC only moves during a frame
   a_mdc_quiet: assert property (@(posedge pclk) disable iff (!presetn_sync)
      $changed(mdc) |-> $past(busy))
      else $error("mdc toggled while the engine was idle");

   a_err_ready: assert property (@(posedge pclk) disable iff (!presetn_sync)
      pslverr |-> pready)
      else $error("pslverr without pready");

   a_irq_cause: assert property (@(posedge pclk) disable iff (!presetn_sync)
      $rose(irq) |-> cmd_seen)
      else $error("irq rose before any command was accepted");

endmodule

bind eth_miim_top eth_miim_checker u_checker (
   .pclk         ( pclk         ),
   .presetn_sync ( presetn_sync ),
   .psel         ( psel         ),
   .penable      ( penable      ),
   .pwrite       ( pwrite       ),
   .paddr        ( paddr        ),
   .pready       ( pready       ),
   .pslverr      ( pslverr      ),
   .irq          ( irq          ),
   .mdc          ( mdc          ),
   .mdo          ( mdo          ),
   .mdo_en       ( mdo_en       ),
   .busy         ( busy         )
);

//--- test/tb_eth_miim.sv
// Testbench for the MII management block.
// APB tasks drive the register map, a PHY model decodes MDIO frames
// and answers reads. Checks are immediate assertions in the tests.

`timescale 1ns/1ps

module tb_eth_miim;

   localparam int PERIOD    = 20;
   localparam int DEF_DIV   = 4;
   // Tests times one full frame at the slowest divider, doubled
   localparam int N_TESTS   = 6;
   localparam int MAX_DIV   = 6;
   localparam int LIMIT_NS  = N_TESTS * 64 * 2 * MAX_DIV * PERIOD * 2;

   logic pclk, presetn_sync, psel, penable, pwrite, mdi;
   logic [4:0] paddr;
   miim_pkg::apb_word_t pwdata, prdata;
   logic pready, pslverr, irq, mdc, mdo, mdo_en;

   int errors, checks, tests, test_err0;
   logic [31:0] seed;
   miim_pkg::mdio_data_t phy_mem [32];

   // PHY model state
   int pre_cnt, last_pre, fbits, frames;
   logic in_frame, is_rd, mdc_q;
   logic [31:0] sh, last_frame;
   logic [4:0] rd_reg;

   eth_miim_top #(.DEFAULT_CLK_DIV(DEF_DIV)) u_eth_miim_top (.*);

   initial
   begin
      pclk = 1'b0;
      forever #(PERIOD / 2) pclk = ~pclk;
   end

   // Watchdog
   initial
   begin
      #(LIMIT_NS);
      $display("Run timed out before all tests finished");
      $display("Test failed");
      $finish;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed;
   endfunction

   // ==============================
   // PHY model, sampled on falling pclk
   // ==============================
   always @(negedge pclk)
   begin
      if (!presetn_sync)
      begin
         mdc_q = 1'b0;
         in_frame = 1'b0;
         pre_cnt = 0;
         fbits = 0;
         frames = 0;
         is_rd = 1'b0;
      end
      else
      begin
         if (mdc && !mdc_q)
         begin
            if (!in_frame && mdo)
               pre_cnt++;
            else
            begin
               in_frame = 1'b1;
               sh = {sh[30:0], mdo_en ? mdo : mdi};
               fbits++;
               // Opcode and addresses are known after 14 bits
               if (fbits == 14)
               begin
                  is_rd  = (sh[11:10] == miim_pkg::OP_READ);
                  rd_reg = sh[4:0];
               end
               if (fbits == 32)
               begin
                  last_frame = sh;
                  last_pre   = pre_cnt;
                  frames++;
                  pre_cnt = 0;
                  fbits = 0;
                  in_frame = 1'b0;
                  is_rd = 1'b0;
               end
            end
            // Value for the next bit, stable long before the next rise
            if (is_rd && fbits == 15)
               mdi = 1'b0;
            else if (is_rd && fbits >= 16)
               mdi = phy_mem[rd_reg][31 - fbits];
            else
               mdi = 1'b1;
         end
         mdc_q = mdc;
      end
   end

   // ==============================
   // APB and checking tasks
   // ==============================
   task automatic apb_access(input logic wr, input logic [4:0] addr, input logic [31:0] wd,
                             output logic [31:0] rd, output logic err, output int stalls);
      stalls = 0;
      @(negedge pclk);
      psel = 1'b1;
      pwrite = wr;
      paddr = addr;
      pwdata = wd;
      @(negedge pclk);
      penable = 1'b1;
      #(PERIOD / 4);
      while (!pready)
      begin
         stalls++;
         @(negedge pclk);
         #(PERIOD / 4);
      end
      rd = prdata;
      err = pslverr;
      @(negedge pclk);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic expect_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      assert (got === exp)
      else
      begin
         $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic reg_write(input logic [4:0] addr, input logic [31:0] wd);
      logic [31:0] rd;
      logic err;
      int st;
      apb_access(1'b1, addr, wd, rd, err, st);
   endtask

   task automatic reg_read(input logic [4:0] addr, output logic [31:0] rd);
      logic err;
      int st;
      apb_access(1'b0, addr, 32'h0, rd, err, st);
   endtask

   // Poll MCR busy with an iteration limit
   task automatic wait_idle();
      logic [31:0] rd;
      int n;
      n = 0;
      rd = 32'hffff_ffff;
      while (rd[31] && n < 4000)
      begin
         reg_read(5'h00, rd);
         n++;
      end
      checks++;
      assert (!rd[31])
      else
      begin
         $display("Engine stayed busy at %0t ns", $time);
         errors++;
      end
   endtask

   function automatic logic [31:0] mcr_word(input logic [1:0] op, input logic [4:0] pa,
                                             input logic [4:0] ra, input logic nopre);
      return {19'h0, nopre, ra, pa, op};
   endfunction

   task automatic end_test(input string name);
      tests++;
      $display("%s: %0d error(s)", name, errors - test_err0);
      test_err0 = errors;
   endtask

   // Half-period of mdc in pclk cycles during a short write frame
   task automatic measure_half(output int half);
      int n;
      half = 0;
      n = 0;
      reg_write(5'h00, mcr_word(miim_pkg::OP_WRITE, 5'd1, 5'd2, 1'b1));
      while (!mdc && n < 100)
      begin
         @(negedge pclk);
         n++;
      end
      while (mdc && half < 100)
      begin
         @(negedge pclk);
         half++;
      end
      wait_idle();
   endtask

   // ==============================
   // Tests
   // ==============================
   initial
   begin
      logic [31:0] rd, wd;
      logic [4:0] pa, ra;
      logic err;
      int st, f0, half;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      mdi = 1'b1;
      errors = 0;
      checks = 0;
      tests = 0;
      test_err0 = 0;
      seed = 32'd4645;
      for (int i = 0; i < 32; i++)
         phy_mem[i] = 16'(lcg_next() >> 8);
      presetn_sync = 1'b0;
      repeat (2) @(negedge pclk);
      presetn_sync = 1'b1;

      #(PERIOD / 4);
      expect_value(32'(pready), 32'd1, "pready after reset");
      expect_value(32'(irq), 32'd0, "irq after reset");
      expect_value(32'(mdo_en), 32'd0, "mdo_en after reset");
      reg_read(5'h08, rd);
      expect_value(rd, DEF_DIV, "DIV reset value");
      end_test("reset values");

      // Write frames with and without preamble
      for (int k = 0; k < 2; k++)
      begin
         wd = lcg_next();
         pa = wd[20:16];
         ra = wd[28:24];
         reg_write(5'h04, {16'h0, wd[15:0]});
         reg_write(5'h00, mcr_word(miim_pkg::OP_WRITE, pa, ra, k[0]));
         wait_idle();
         expect_value(last_frame, {2'b01, miim_pkg::OP_WRITE, pa, ra, 2'b10, wd[15:0]},
                      "write frame bits");
         expect_value(last_pre, k ? 0 : miim_pkg::PREAMBLE_BITS, "preamble length");
      end
      end_test("write frames");

      // Read frame and interrupt
      reg_write(5'h0c, 32'h3);
      expect_value(32'(irq), 32'd0, "irq after clear");
      ra = 5'(lcg_next() >> 27);
      reg_write(5'h00, mcr_word(miim_pkg::OP_READ, 5'd3, ra, 1'b0));
      wait_idle();
      reg_read(5'h04, rd);
      expect_value(rd, {16'h0, phy_mem[ra]}, "MDR after read");
      expect_value(32'(irq), 32'd1, "irq after read");
      reg_write(5'h0c, 32'h3);
      expect_value(32'(irq), 32'd0, "irq after write-one-clear");
      end_test("read frame and irq");

      // Command write while busy stalls until the frame ends
      f0 = frames;
      reg_write(5'h04, 32'h0000_a5c3);
      reg_write(5'h00, mcr_word(miim_pkg::OP_WRITE, 5'd7, 5'd9, 1'b0));
      apb_access(1'b1, 5'h00, mcr_word(miim_pkg::OP_WRITE, 5'd4, 5'd5, 1'b1), rd, err, st);
      expect_value(32'(st > 0), 32'd1, "pready stalled");
      expect_value(frames, f0 + 1, "first frame done before accept");
      wait_idle();
      expect_value(frames, f0 + 2, "second frame ran");
      expect_value(last_frame, {2'b01, miim_pkg::OP_WRITE, 5'd4, 5'd5, 2'b10, 16'ha5c3},
                   "second frame bits");
      end_test("busy stall");

      // Unmapped and mapped offsets
      for (int a = 0; a < 8; a++)
      begin
         apb_access(1'b0, 5'(a * 4), 32'h0, rd, err, st);
         expect_value(32'(err), 32'(a >= 4), "pslverr on read");
         if (a >= 4)
            expect_value(rd, 32'h0, "unmapped read data");
      end
      apb_access(1'b1, 5'h14, 32'hffff_ffff, rd, err, st);
      expect_value(32'(err), 32'd1, "pslverr on unmapped write");
      end_test("address decode");

      // Divider clamp and measured mdc half-period
      reg_write(5'h08, 32'h0);
      reg_read(5'h08, rd);
      expect_value(rd, 32'd2, "DIV clamp");
      measure_half(half);
      expect_value(half, 2, "mdc half-period at DIV 0");
      reg_write(5'h08, 32'd6);
      measure_half(half);
      expect_value(half, 6, "mdc half-period at DIV 6");
      end_test("mdc divider");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- compile.f
source/miim_pkg.sv
source/miim_apb_slave.sv
source/miim_regs.sv
source/miim_mdc_gen.sv
source/miim_frame_engine.sv
source/eth_miim_top.sv
test/eth_miim_checker.sv
test/tb_eth_miim.sv

//--- Makefile
# Verilator build and run for the MII management testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, log in sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_eth_miim -f compile.f
	./obj_dir/Vtb_eth_miim > sim.log 2>&1; st=$$?; cat sim.log; \
	if grep -q "Test failed" sim.log || [ $$st -ne 0 ]; then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
